//--- bitrev_serializer.sv
module bitrev_serializer #(
  parameter  int N_SAMPLES = 8,
  localparam int IDX_W     = $clog2(N_SAMPLES)
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 recv_val,
  output logic                 recv_rdy,
  input  reorder_pkg::sample_t recv_msg [N_SAMPLES],
  output logic                 send_val,
  input  logic                 send_rdy,
  output reorder_pkg::sample_t send_msg
);
  import reorder_pkg::*;

  sample_t          hold [N_SAMPLES];
  logic             load;
  logic [IDX_W-1:0] rd_index;

  ser_ctrl #(.N_SAMPLES(N_SAMPLES)) ctrl (
    .clk      (clk),
    .reset    (reset),
    .recv_val (recv_val),
    .send_rdy (send_rdy),
    .recv_rdy (recv_rdy),
    .send_val (send_val),
    .load     (load),
    .rd_index (rd_index)
  );

  // ##########################################################
  // Holding register and read mux
  // ##########################################################

  always_ff @(posedge clk) begin
    if (load) begin
      hold <= recv_msg;  // Frees the deserializer to fill the next block.
    end
  end

  assign send_msg = hold[rd_index];

endmodule

//--- deser_ctrl.sv
module deser_ctrl #(
  parameter  int N_SAMPLES = 8,
  localparam int IDX_W     = $clog2(N_SAMPLES)
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 recv_val,
  input  logic                 send_rdy,
  output logic                 recv_rdy,
  output logic                 send_val,
  output logic [N_SAMPLES-1:0] wr_en
);
  import reorder_pkg::*;

  deser_state_t     state;
  deser_state_t     state_next;
  logic [IDX_W-1:0] index;
  logic             last;
  logic             accept;
  logic             xfer;

  assign recv_rdy = (state == FILL);
  assign send_val = (state == FULL);
  assign accept   = recv_val && recv_rdy;  // One sample taken this cycle.
  assign xfer     = send_val && send_rdy;  // Block handed to the next stage.

  sample_counter #(.N_SAMPLES(N_SAMPLES)) counter (
    .clk     (clk),
    .reset   (reset),
    .clear   (xfer),
    .advance (accept),
    .index   (index),
    .last    (last)
  );

  assign wr_en = accept ? (N_SAMPLES'(1) << index) : '0;  // One-hot write select.

  always_comb begin
    state_next = state;
    case (state)
      FILL: begin
        if (accept && last) begin
          state_next = FULL;
        end
      end
      FULL: begin
        if (send_rdy) begin
          state_next = FILL;
        end
      end
      default: state_next = FILL;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= FILL;
    end else begin
      state <= state_next;
    end
  end

endmodule

//--- deserializer.sv
module deserializer #(
  parameter int N_SAMPLES = 8
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                recv_val,
  output logic                recv_rdy,
  input  reorder_pkg::sample_t recv_msg,
  output logic                send_val,
  input  logic                send_rdy,
  output reorder_pkg::sample_t send_msg [N_SAMPLES]
);

  logic [N_SAMPLES-1:0] wr_en;

  deser_ctrl #(.N_SAMPLES(N_SAMPLES)) ctrl (
    .clk      (clk),
    .reset    (reset),
    .recv_val (recv_val),
    .send_rdy (send_rdy),
    .recv_rdy (recv_rdy),
    .send_val (send_val),
    .wr_en    (wr_en)
  );

  // ##########################################################
  // Sample register bank
  // ##########################################################

  for (genvar i = 0; i < N_SAMPLES; i++) begin : g_regs
    always_ff @(posedge clk) begin
      if (reset) begin
        send_msg[i] <= '0;
      end else if (wr_en[i]) begin
        send_msg[i] <= recv_msg;  // Slot i takes the sample with index i.
      end
    end
  end

endmodule

//--- list.f
reorder_pkg.sv
sample_counter.sv
deser_ctrl.sv
deserializer.sv
ser_ctrl.sv
bitrev_serializer.sv
reorder_top.sv
tb_clock.sv
reorder_chk.sv
reorder_tb.sv

//--- reorder_chk.sv
module reorder_chk (
  input logic                 clk,
  input logic                 reset,
  input logic                 in_val,
  input logic                 in_rdy,
  input reorder_pkg::sample_t in_msg,
  input logic                 out_val,
  input logic                 out_rdy,
  input reorder_pkg::sample_t out_msg,
  input logic                 block_val
);

  // ##########################################################
  // Handshake rules at the two external ports
  // ##########################################################

  in_msg_held: assert property (@(posedge clk) disable iff (reset)
      (in_val && !in_rdy) |=> (in_val && $stable(in_msg)))
    else $error("in_msg or in_val changed while in_rdy was low");

  out_msg_held: assert property (@(posedge clk) disable iff (reset)
      (out_val && !out_rdy) |=> (out_val && $stable(out_msg)))
    else $error("out_msg or out_val changed while out_rdy was low");

  // Both controllers start empty.
  reset_state: assert property (@(posedge clk)
      reset |=> (in_rdy && !out_val && !block_val))
    else $error("handshake outputs not idle after reset");

  // FILL and FULL are exclusive, so the deserializer never offers and accepts at once.
  deser_exclusive: assert property (@(posedge clk)
      !(block_val && in_rdy))
    else $error("deserializer shows send_val and recv_rdy together");

endmodule

//--- reorder_pkg.sv
package reorder_pkg;

  // ##########################################################
  // Data types
  // ##########################################################

  typedef logic [15:0] sample_t;  // One input or output sample.

  // ##########################################################
  // Controller states
  // ##########################################################

  typedef enum logic {
    FILL,  // Gathering samples into the register bank.
    FULL   // Whole block presented, waiting for the serializer.
  } deser_state_t;

  typedef enum logic {
    IDLE,  // Ready for the next block.
    DRAIN  // Sending the held block in bit-reversed order.
  } ser_state_t;

  // Block length used when the top level is not overridden.
  parameter int DEFAULT_N_SAMPLES = 8;

endpackage

//--- reorder_tb.sv
module reorder_tb #(
  parameter int N_SAMPLES = reorder_pkg::DEFAULT_N_SAMPLES
);
  import reorder_pkg::*;

  localparam int IDX_W      = $clog2(N_SAMPLES);
  localparam int N_BLOCKS   = 6;
  localparam int TOTAL      = N_BLOCKS * N_SAMPLES;
  localparam int MAX_CYCLES = 6 * TOTAL + 100;

  logic    clk;
  logic    reset;
  logic    in_val;
  logic    in_rdy;
  sample_t in_msg;
  logic    out_val;
  logic    out_rdy;
  sample_t out_msg;

  sample_t vec [2*TOTAL];  // Pairs of input sample and expected output.
  sample_t in_samples [TOTAL];
  sample_t expected [TOTAL];

  int   seed          = 32'h324bb33e;
  int   errors        = 0;
  int   cycles        = 0;
  int   in_count      = 0;
  int   received      = 0;
  int   last_in_cycle = 0;
  logic overlap_seen  = 1'b0;

  tb_clock #(.PERIOD(8)) clock_gen (.clk(clk));

  reorder_top #(.N_SAMPLES(N_SAMPLES)) dut (
    .clk     (clk),
    .reset   (reset),
    .in_val  (in_val),
    .in_rdy  (in_rdy),
    .in_msg  (in_msg),
    .out_val (out_val),
    .out_rdy (out_rdy),
    .out_msg (out_msg)
  );

  bind reorder_top reorder_chk chk (
    .clk       (clk),
    .reset     (reset),
    .in_val    (in_val),
    .in_rdy    (in_rdy),
    .in_msg    (in_msg),
    .out_val   (out_val),
    .out_rdy   (out_rdy),
    .out_msg   (out_msg),
    .block_val (block_val)
  );

  function automatic int bit_reverse(input int k);
    int r;
    r = 0;
    for (int i = 0; i < IDX_W; i++) begin
      if (k[i]) begin
        r = r | (1 << (IDX_W - 1 - i));
      end
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  // ##########################################################
  // Stimulus
  // ##########################################################

  initial begin
    int   sent;
    int   src;
    logic holding;
    logic burst;
    sent    = 0;
    holding = 1'b0;
    reset   = 1'b1;
    in_val  = 1'b0;
    in_msg  = '0;
    out_rdy = 1'b0;
    $readmemh("reorder_vectors.txt", vec);
    if ($isunknown(vec[2*TOTAL-1])) begin
      errors++;
      $display("Vector file reorder_vectors.txt is missing or too short.");
    end
    for (int i = 0; i < TOTAL; i++) begin
      in_samples[i] = vec[2*i];
      expected[i]   = vec[2*i+1];
    end
    // Position k of block b holds input sample b*N + bitrev(k).
    for (int i = 0; i < TOTAL; i++) begin
      src = (i / N_SAMPLES) * N_SAMPLES + bit_reverse(i % N_SAMPLES);
      check_value("vector expected", 32'(expected[i]), 32'(in_samples[src]));
    end
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    check_value("in_rdy after reset", 32'(in_rdy), 1);
    check_value("out_val after reset", 32'(out_val), 0);
    while (sent < TOTAL) begin
      @(posedge clk);
      #1;
      burst = (sent < 2 * N_SAMPLES);  // First two blocks stream with no gaps.
      if (!holding) begin
        if (burst || (($random(seed) & 3) != 0)) begin
          in_val  = 1'b1;
          in_msg  = in_samples[sent];
          holding = 1'b1;
        end else begin
          in_val = 1'b0;
        end
      end
      out_rdy = burst || (($random(seed) & 3) != 0);
      @(negedge clk);
      if (in_val && in_rdy) begin
        sent++;
        holding = 1'b0;
      end
    end
    @(posedge clk);
    #1;
    in_val = 1'b0;
    while (received < TOTAL) begin
      @(posedge clk);
      #1;
      out_rdy = (($random(seed) & 3) != 0);
    end
    out_rdy = 1'b1;
    repeat (2 * N_SAMPLES) @(posedge clk);
    #1;
    check_value("out_val at end", 32'(out_val), 0);
    check_value("output count", received, TOTAL);
    check_value("fill during drain", 32'(overlap_seen), 1);
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // ##########################################################
  // Output monitor and run limit
  // ##########################################################

  // Sampled mid-cycle, so a handshake seen here completes on the next edge.
  always @(negedge clk) begin
    if (!reset) begin
      if (in_val && in_rdy) begin
        in_count++;
        if (in_count == N_SAMPLES) begin
          last_in_cycle = cycles;
        end
      end
      if (out_val && out_rdy) begin
        if (received >= TOTAL) begin
          errors++;
          $display("Extra output %h seen after all %0d expected outputs.", out_msg, TOTAL);
        end else begin
          if (received == 0) begin
            check_value("first output latency", 32'(cycles - last_in_cycle), 2);
          end
          check_value("out_msg", 32'(out_msg), 32'(expected[received]));
          received++;
        end
        if (in_val && in_rdy) begin
          overlap_seen = 1'b1;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles with %0d of %0d outputs received.",
               cycles, received, TOTAL);
      $display("** FAIL **");
      $finish;
    end
  end

endmodule

//--- reorder_top.sv
module reorder_top #(
  parameter int N_SAMPLES = reorder_pkg::DEFAULT_N_SAMPLES
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 in_val,
  output logic                 in_rdy,
  input  reorder_pkg::sample_t in_msg,
  output logic                 out_val,
  input  logic                 out_rdy,
  output reorder_pkg::sample_t out_msg
);
  import reorder_pkg::*;

  logic    block_val;
  logic    block_rdy;
  sample_t block_msg [N_SAMPLES];  // Whole block between the two stages.

  deserializer #(.N_SAMPLES(N_SAMPLES)) deser (
    .clk      (clk),
    .reset    (reset),
    .recv_val (in_val),
    .recv_rdy (in_rdy),
    .recv_msg (in_msg),
    .send_val (block_val),
    .send_rdy (block_rdy),
    .send_msg (block_msg)
  );

  bitrev_serializer #(.N_SAMPLES(N_SAMPLES)) ser (
    .clk      (clk),
    .reset    (reset),
    .recv_val (block_val),
    .recv_rdy (block_rdy),
    .recv_msg (block_msg),
    .send_val (out_val),
    .send_rdy (out_rdy),
    .send_msg (out_msg)
  );

endmodule

//--- reorder_vectors.txt
// Columns: input sample in arrival order, expected output at the same position.
// Expected output k of block b is input b*8 + bitrev3(k).
// block 0
0000 0000
0001 0004
0002 0002
0003 0006
0004 0001
0005 0005
0006 0003
0007 0007
// block 1
1001 1001
1111 1441
1221 1221
1331 1661
1441 1111
1551 1551
1661 1331
1771 1771
// block 2
2002 2002
2112 2442
2222 2222
2332 2662
2442 2112
2552 2552
2662 2332
2772 2772
// block 3
3003 3003
3113 3443
3223 3223
3333 3663
3443 3113
3553 3553
3663 3333
3773 3773
// block 4
4004 4004
4114 4444
4224 4224
4334 4664
4444 4114
4554 4554
4664 4334
4774 4774
// block 5
5005 5005
5115 5445
5225 5225
5335 5665
5445 5115
5555 5555
5665 5335
5775 5775

//--- run.sh
#!/usr/bin/env bash
# Build the reorder testbench with Verilator, run it, and check the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module reorder_tb \
  -f list.f -Mdir obj_dir -o reorder_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed."
  exit 1
fi

./obj_dir/reorder_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status."
  exit 1
fi

if grep -q -F '** FAIL **' "$LOG"; then
  echo "Testbench reported failure, see $LOG."
  exit 1
fi

echo "Simulation finished without reported failure."
exit 0

//--- sample_counter.sv
module sample_counter #(
  parameter  int N_SAMPLES = 8,
  localparam int IDX_W     = $clog2(N_SAMPLES)
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             clear,
  input  logic             advance,
  output logic [IDX_W-1:0] index,
  output logic             last
);

  // The block length is a power of two, so the natural wrap of the
  // index register returns it to zero after the last sample.
  always_ff @(posedge clk) begin
    if (reset) begin
      index <= '0;
    end else if (clear) begin
      index <= '0;  // Clear wins over advance.
    end else if (advance) begin
      index <= index + IDX_W'(1);
    end
  end

  assign last = (index == IDX_W'(N_SAMPLES - 1));

endmodule

//--- ser_ctrl.sv
module ser_ctrl #(
  parameter  int N_SAMPLES = 8,
  localparam int IDX_W     = $clog2(N_SAMPLES)
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             recv_val,
  input  logic             send_rdy,
  output logic             recv_rdy,
  output logic             send_val,
  output logic             load,
  output logic [IDX_W-1:0] rd_index
);
  import reorder_pkg::*;

  ser_state_t       state;
  ser_state_t       state_next;
  logic [IDX_W-1:0] index;
  logic             last;
  logic             advance;

  assign recv_rdy = (state == IDLE);
  assign send_val = (state == DRAIN);
  assign load     = recv_val && recv_rdy;  // Block transfer edge.
  assign advance  = send_val && send_rdy;  // One output sample sent.

  sample_counter #(.N_SAMPLES(N_SAMPLES)) counter (
    .clk     (clk),
    .reset   (reset),
    .clear   (load),
    .advance (advance),
    .index   (index),
    .last    (last)
  );

  // Mirror the index bits to get the in-place FFT input order.
  always_comb begin
    for (int i = 0; i < IDX_W; i++) begin
      rd_index[i] = index[IDX_W-1-i];
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (load) begin
          state_next = DRAIN;
        end
      end
      DRAIN: begin
        if (advance && last) begin
          state_next = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

endmodule

//--- tb_clock.sv
module tb_clock #(
  parameter int PERIOD = 8
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;  // Free-running testbench clock.
  end

endmodule
